/* verilog.f */
hw/systolic_pkg.sv
hw/systolic_ctrl.sv
hw/step_counter.sv
hw/data_feeder.sv
hw/pe.sv
hw/systolic_top.sv
verification/systolic_sva.sv
verification/tb_systolic.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the systolic multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_systolic -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output="$(./obj_dir/sim_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

/* verification/tb_systolic.sv */
// tb_systolic
// random signed byte jobs through the 4x4 systolic multiplier, checked
// against a plain matrix product computed here, plus handshake timing,
// ignored busy starts, result hold and back-to-back jobs

`default_nettype none
`timescale 1ns/1ps

module tb_systolic;

    localparam int NUM_JOBS     = 40;
    localparam int MAX_CYCLES   = NUM_JOBS * 20 + 200;
    localparam int DONE_LATENCY = 13;  // LOAD, eleven RUN steps, DONE

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      start_i;
    systolic_pkg::matrix_in_t  matrix_a_i;
    systolic_pkg::matrix_in_t  matrix_b_i;
    logic                      ready_o;
    logic                      done_o;
    systolic_pkg::matrix_out_t result_o;

    int errors = 0;
    int checks = 0;
    int cycle_count = 0;

    systolic_top u_systolic_top (
        .clk        (clk),
        .reset      (reset),
        .start_i    (start_i),
        .matrix_a_i (matrix_a_i),
        .matrix_b_i (matrix_b_i),
        .ready_o    (ready_o),
        .done_o     (done_o),
        .result_o   (result_o)
    );

    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: no finish after %0d cycles, DUT stuck or done_o missing",
                     cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // C[i][j] = sum over k of a[i][k] * b[k][j], element [0][0] at the top
    function automatic systolic_pkg::matrix_out_t model_product(
        input systolic_pkg::matrix_in_t a,
        input systolic_pkg::matrix_in_t b
    );
        systolic_pkg::matrix_out_t c;
        systolic_pkg::acc_t        sum;
        systolic_pkg::operand_t    a_ik;
        systolic_pkg::operand_t    b_kj;
        c = '0;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                sum = '0;
                for (int k = 0; k < 4; k++) begin
                    a_ik = a[(15 - (4 * i + k)) * 8 +: 8];
                    b_kj = b[(15 - (4 * k + j)) * 8 +: 8];
                    sum  = sum + systolic_pkg::acc_t'(a_ik) * systolic_pkg::acc_t'(b_kj);
                end
                c[(15 - (4 * i + j)) * 32 +: 32] = sum;
            end
        end
        return c;
    endfunction

    // extremes show up often on purpose
    function automatic systolic_pkg::operand_t random_element();
        int pick;
        pick = int'($urandom % 8);
        if (pick == 0) begin
            return -8'sd128;
        end else if (pick == 1) begin
            return 8'sd127;
        end
        return systolic_pkg::operand_t'($urandom);
    endfunction

    function automatic systolic_pkg::matrix_in_t random_matrix();
        systolic_pkg::matrix_in_t m;
        for (int e = 0; e < 16; e++) begin
            m[e * 8 +: 8] = random_element();
        end
        return m;
    endfunction

    task automatic check_result(input string name, input systolic_pkg::matrix_out_t actual,
                                input systolic_pkg::matrix_out_t expected);
        systolic_pkg::acc_t got;
        systolic_pkg::acc_t want;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                got  = actual[(15 - (4 * i + j)) * 32 +: 32];
                want = expected[(15 - (4 * i + j)) * 32 +: 32];
                checks++;
                if (got !== want) begin
                    errors++;
                    $display("MISMATCH at %0t: %s[%0d][%0d] expected %0d actual %0d",
                             $time, name, i, j, want, got);
                end
            end
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_cycles(input string name, input int actual, input int expected);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    // outputs have settled and inputs change here
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic run_job(input systolic_pkg::matrix_in_t a, input systolic_pkg::matrix_in_t b,
                           input bit busy_pulse, input int gap,
                           input systolic_pkg::matrix_out_t prev,
                           output systolic_pkg::matrix_out_t expected);
        int n;
        expected = model_product(a, b);
        while (!ready_o) begin
            next_cycle();
        end
        start_i    = 1'b1;
        matrix_a_i = a;
        matrix_b_i = b;
        next_cycle();  // accepting edge
        start_i = 1'b0;
        n = 1;
        check_result("result_o", result_o, prev);  // old result still held in LOAD
        while (!done_o && n < DONE_LATENCY + 5) begin
            check_flag("ready_o", ready_o, 1'b0);
            if (busy_pulse && n == 4) begin
                start_i    = 1'b1;  // must be ignored, DUT is busy
                matrix_a_i = random_matrix();
                matrix_b_i = random_matrix();
            end else begin
                start_i = 1'b0;
            end
            next_cycle();
            n++;
        end
        start_i = 1'b0;
        check_cycles("done_o latency", n, DONE_LATENCY);
        check_flag("ready_o", ready_o, 1'b0);
        check_result("result_o", result_o, expected);
        next_cycle();
        check_flag("done_o", done_o, 1'b0);
        check_flag("ready_o", ready_o, 1'b1);
        check_result("result_o", result_o, expected);
        for (int g = 0; g < gap; g++) begin
            next_cycle();
            check_flag("done_o", done_o, 1'b0);
            check_result("result_o", result_o, expected);
        end
    endtask

    initial begin
        systolic_pkg::matrix_out_t prev;
        systolic_pkg::matrix_out_t expected;
        int gap;
        void'($urandom(32'h1798));
        reset      = 1'b1;
        start_i    = 1'b0;
        matrix_a_i = '0;
        matrix_b_i = '0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        check_flag("ready_o", ready_o, 1'b1);
        check_flag("done_o", done_o, 1'b0);
        check_result("result_o", result_o, '0);
        prev = '0;
        for (int job = 0; job < NUM_JOBS; job++) begin
            gap = (job % 5 == 0) ? 0 : int'($urandom % 4);  // gap 0 is back-to-back
            run_job(random_matrix(), random_matrix(), job % 3 == 1, gap, prev, expected);
            prev = expected;
        end
        $display("jobs %0d, checks %0d, errors %0d", NUM_JOBS, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/systolic_sva.sv */
// systolic_sva
// handshake and done timing properties of the systolic multiplier

`default_nettype none
`timescale 1ns/1ps

module systolic_sva (
    input logic clk,
    input logic reset,
    input logic start_i,
    input logic ready_o,
    input logic done_o
);

    logic       accepted;
    logic [3:0] busy_left;  // cycles of the current job still to come

    assign accepted = start_i && ready_o;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy_left <= '0;
        end else if (accepted) begin
            busy_left <= 4'd13;
        end else if (busy_left != 4'd0) begin
            busy_left <= busy_left - 4'd1;
        end
    end

    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        done_o |=> !done_o)
        else $error("done_o high for more than one cycle");

    ready_low_busy: assert property (@(posedge clk) disable iff (reset)
        (done_o || busy_left != 4'd0) |-> !ready_o)
        else $error("ready_o high while a job is in flight");

    done_after_start: assert property (@(posedge clk) disable iff (reset)
        $past(accepted, 13) |-> done_o)
        else $error("done_o missing 13 cycles after an accepted start");

    done_only_after_start: assert property (@(posedge clk) disable iff (reset)
        done_o |-> $past(accepted, 13))
        else $error("done_o without an accepted start 13 cycles earlier");

endmodule

bind systolic_top systolic_sva u_systolic_sva (
    .clk     (clk),
    .reset   (reset),
    .start_i (start_i),
    .ready_o (ready_o),
    .done_o  (done_o)
);

`default_nettype wire

/* hw/systolic_top.sv */
// systolic_top
// 4x4 signed byte matrix multiplier, C = A x B
// A rows enter from the left and B columns from the top, each lane skewed
// by its index so that PE[i][j] meets a[i][k] and b[k][j] at step i+j+k

`default_nettype none
`timescale 1ns/1ps

module systolic_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start_i,
    input  systolic_pkg::matrix_in_t  matrix_a_i,
    input  systolic_pkg::matrix_in_t  matrix_b_i,
    output logic                      ready_o,
    output logic                      done_o,
    output systolic_pkg::matrix_out_t result_o
);

    logic load;
    logic run;
    logic last;

    systolic_pkg::lane_t    lane_a [systolic_pkg::N_DIM];
    systolic_pkg::lane_t    lane_b [systolic_pkg::N_DIM];
    systolic_pkg::operand_t a_bus  [systolic_pkg::N_DIM][systolic_pkg::N_DIM+1];
    systolic_pkg::operand_t b_bus  [systolic_pkg::N_DIM+1][systolic_pkg::N_DIM];
    systolic_pkg::acc_t     acc    [systolic_pkg::N_DIM][systolic_pkg::N_DIM];

    systolic_ctrl u_ctrl (
        .clk     (clk),
        .reset   (reset),
        .start_i (start_i),
        .last_i  (last),
        .load_o  (load),
        .run_o   (run),
        .ready_o (ready_o),
        .done_o  (done_o)
    );

    step_counter u_step_counter (
        .clk        (clk),
        .reset      (reset),
        .clear_i    (load),
        .count_en_i (run),
        .last_o     (last)
    );

    // skewed lanes, byte position p = lane + k from the top, pads are zero
    always_comb begin
        for (int i = 0; i < systolic_pkg::N_DIM; i++) begin
            lane_a[i] = '0;
            lane_b[i] = '0;
            for (int k = 0; k < systolic_pkg::N_DIM; k++) begin
                lane_a[i][(systolic_pkg::LANE_LEN-1-(i+k))*8 +: 8] =
                    matrix_a_i[(systolic_pkg::N_DIM*systolic_pkg::N_DIM-1-
                                (systolic_pkg::N_DIM*i+k))*8 +: 8];  // a[i][k]
                lane_b[i][(systolic_pkg::LANE_LEN-1-(i+k))*8 +: 8] =
                    matrix_b_i[(systolic_pkg::N_DIM*systolic_pkg::N_DIM-1-
                                (systolic_pkg::N_DIM*k+i))*8 +: 8];  // b[k][i]
            end
        end
    end

    for (genvar i = 0; i < systolic_pkg::N_DIM; i++) begin : g_feed
        data_feeder u_feed_a (
            .clk     (clk),
            .reset   (reset),
            .load_i  (load),
            .shift_i (run),
            .lane_i  (lane_a[i]),
            .data_o  (a_bus[i][0])
        );

        data_feeder u_feed_b (
            .clk     (clk),
            .reset   (reset),
            .load_i  (load),
            .shift_i (run),
            .lane_i  (lane_b[i]),
            .data_o  (b_bus[0][i])
        );
    end

    for (genvar i = 0; i < systolic_pkg::N_DIM; i++) begin : g_row
        for (genvar j = 0; j < systolic_pkg::N_DIM; j++) begin : g_col
            pe u_pe (
                .clk      (clk),
                .reset    (reset),
                .clear_i  (load),
                .acc_en_i (run),
                .a_i      (a_bus[i][j]),
                .b_i      (b_bus[i][j]),
                .a_o      (a_bus[i][j+1]),
                .b_o      (b_bus[i+1][j]),
                .acc_o    (acc[i][j])
            );
        end
    end

    // accumulators hold from the last run step until the next LOAD
    always_comb begin
        for (int i = 0; i < systolic_pkg::N_DIM; i++) begin
            for (int j = 0; j < systolic_pkg::N_DIM; j++) begin
                result_o[(systolic_pkg::N_DIM*systolic_pkg::N_DIM-1-
                          (systolic_pkg::N_DIM*i+j))*32 +: 32] = acc[i][j];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/pe.sv */
// pe
// multiply-accumulate cell of the output-stationary mesh
// a moves right and b moves down through one register per hop,
// while the product of the incoming pair is added to the local sum

`default_nettype none
`timescale 1ns/1ps

module pe (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clear_i,
    input  logic                   acc_en_i,
    input  systolic_pkg::operand_t a_i,
    input  systolic_pkg::operand_t b_i,
    output systolic_pkg::operand_t a_o,
    output systolic_pkg::operand_t b_o,
    output systolic_pkg::acc_t     acc_o
);

    logic signed [15:0] product;

    assign product = 16'(a_i) * 16'(b_i);  // full signed 8x8 product

    // operand forwarding to the right and lower neighbours
    always_ff @(posedge clk) begin
        if (clear_i) begin
            a_o <= '0;
            b_o <= '0;
        end else begin
            a_o <= a_i;
            b_o <= b_i;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc_o <= '0;
        end else if (clear_i) begin
            acc_o <= '0;
        end else if (acc_en_i) begin
            acc_o <= acc_o + systolic_pkg::acc_t'(product);  // sign extended
        end
    end

endmodule

`default_nettype wire

/* hw/data_feeder.sv */
// data_feeder
// holds one skewed operand lane and hands out its top byte each run step
// zeros are shifted in behind the data, and the output is zero outside RUN

`default_nettype none
`timescale 1ns/1ps

module data_feeder (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load_i,
    input  logic                  shift_i,
    input  systolic_pkg::lane_t   lane_i,
    output systolic_pkg::operand_t data_o
);

    systolic_pkg::lane_t lane_q;

    always_ff @(posedge clk) begin
        if (load_i) begin
            lane_q <= lane_i;
        end else if (shift_i) begin
            lane_q <= lane_q << 8;  // backfill with zero bytes
        end
    end

    // registered output byte, one cycle behind the shift
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data_o <= '0;
        end else if (shift_i) begin
            data_o <= systolic_pkg::operand_t'(lane_q[systolic_pkg::LANE_LEN*8-1 -: 8]);
        end else begin
            data_o <= '0;  // mesh only sees zeros around a job
        end
    end

endmodule

`default_nettype wire

/* hw/step_counter.sv */
// step_counter
// counts run-phase cycles and flags the final one to the controller

`default_nettype none
`timescale 1ns/1ps

module step_counter (
    input  logic clk,
    input  logic reset,
    input  logic clear_i,
    input  logic count_en_i,
    output logic last_o
);

    systolic_pkg::step_t count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (clear_i) begin
            count <= '0;  // zeroed during LOAD
        end else if (count_en_i) begin
            count <= count + systolic_pkg::step_t'(1);
        end
    end

    // high throughout the last run step
    assign last_o = (count == systolic_pkg::step_t'(systolic_pkg::RUN_STEPS - 1));

endmodule

`default_nettype wire

/* hw/systolic_ctrl.sv */
// systolic_ctrl
// sequences one job through load, run and done phases
// ready is only offered in IDLE, so a start outside IDLE is dropped
// the run phase ends when the step counter flags its last step

`default_nettype none
`timescale 1ns/1ps

module systolic_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic start_i,
    input  logic last_i,
    output logic load_o,
    output logic run_o,
    output logic ready_o,
    output logic done_o
);

    systolic_pkg::ctrl_state_t state;
    systolic_pkg::ctrl_state_t state_next;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= systolic_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // next state
    always_comb begin
        state_next = state;
        case (state)
            systolic_pkg::IDLE: begin
                if (start_i) begin  // ready is high here, so the job is accepted
                    state_next = systolic_pkg::LOAD;
                end
            end
            systolic_pkg::LOAD: begin
                state_next = systolic_pkg::RUN;
            end
            systolic_pkg::RUN: begin
                if (last_i) begin
                    state_next = systolic_pkg::DONE;
                end
            end
            systolic_pkg::DONE: begin
                state_next = systolic_pkg::IDLE;
            end
            default: begin
                state_next = systolic_pkg::IDLE;
            end
        endcase
    end

    // moore outputs, one state each
    always_comb begin
        load_o  = (state == systolic_pkg::LOAD);  // feeders load, accumulators clear
        run_o   = (state == systolic_pkg::RUN);
        done_o  = (state == systolic_pkg::DONE);
        ready_o = (state == systolic_pkg::IDLE);
    end

endmodule

`default_nettype wire

/* hw/systolic_pkg.sv */
// systolic_pkg
// shared widths, step counts and types for the 4x4 signed byte
// matrix multiplier built as an output-stationary systolic array

`default_nettype none

package systolic_pkg;

    localparam int N_DIM     = 4;   // matrix dimension
    localparam int LANE_LEN  = 7;   // four data bytes plus three skew pads
    localparam int RUN_STEPS = 11;  // ten propagation steps plus one settle step

    // one signed matrix element
    typedef logic signed [7:0] operand_t;

    // one accumulated element of C
    typedef logic signed [31:0] acc_t;

    // packed operand matrix, row-major, element [0][0] in the top byte
    typedef logic [N_DIM*N_DIM*8-1:0] matrix_in_t;

    // packed result matrix, row-major, C[0][0] in the top word
    typedef logic [N_DIM*N_DIM*32-1:0] matrix_out_t;

    // contents of one skewing feeder, first byte out sits at the top
    typedef logic [LANE_LEN*8-1:0] lane_t;

    typedef logic [3:0] step_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        RUN,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire
